// File: compile.f
source/cpu_isa_pkg.sv
source/cpu_pipe_pkg.sv
source/fetch_unit.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/pipeline_cpu.sv
verification/pipeline_cpu_sva.sv
verification/pipeline_cpu_tb.sv

// File: source/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  shamt_t;

    // primary opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    // R-type function field
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_e;

    // add is zero so a cleared ctrl bundle is harmless
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7,
        ALU_LUI = 4'd8
    } alu_op_e;

endpackage

`default_nettype wire

// File: source/cpu_pipe_pkg.sv
`default_nettype none

package cpu_pipe_pkg;

    import cpu_isa_pkg::*;

    // decoded control that travels with the instruction
    typedef struct packed {
        logic    reg_write;
        logic    mem_write;
        logic    mem_to_reg;
        logic    alu_src_imm;
        logic    shift_by_shamt;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        word_t pc_plus4;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     op_a;
        word_t     op_b;
        word_t     imm;
        shamt_t    shamt;
        reg_addr_t dest;
    } id_ex_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t dest;
    } ex_mem_t;

    // only the writeback part of ctrl survives past memory
    typedef struct packed {
        logic      reg_write;
        logic      mem_to_reg;
        word_t     alu_result;
        word_t     mem_data;
        reg_addr_t dest;
    } mem_wb_t;

endpackage

`default_nettype wire

// File: source/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         en,
    input  wire cpu_pipe_pkg::if_id_t   if_id,
    input  wire cpu_pipe_pkg::id_ex_t   ex_fwd,
    input  wire cpu_isa_pkg::word_t     ex_result,
    input  wire cpu_pipe_pkg::ex_mem_t  mem_fwd,
    input  wire cpu_isa_pkg::word_t     mem_rdata,
    input  wire                         wb_en,
    input  wire cpu_isa_pkg::reg_addr_t wb_addr,
    input  wire cpu_isa_pkg::word_t     wb_data,
    output logic                        stall,
    output logic                        redirect,
    output cpu_isa_pkg::word_t          redirect_pc,
    output cpu_pipe_pkg::id_ex_t        id_ex
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    opcode_e   opcode;
    funct_e    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    reg_addr_t dest;
    shamt_t    shamt;
    ctrl_t     ctrl;
    word_t     imm_ext;
    word_t     rs_rf;
    word_t     rt_rf;
    word_t     rs_val;
    word_t     rt_val;
    logic      uses_rs;
    logic      uses_rt;
    logic      is_beq;
    logic      is_bne;
    logic      is_jump;
    logic      taken;
    logic      ex_is_load;

    assign opcode = opcode_e'(if_id.instr[31:26]);
    assign funct  = funct_e'(if_id.instr[5:0]);
    assign rs     = if_id.instr[25:21];
    assign rt     = if_id.instr[20:16];
    assign rd     = if_id.instr[15:11];
    assign shamt  = if_id.instr[10:6];

    register_file u_regs (
        .clk     (clk),
        .rs_addr (rs),
        .rt_addr (rt),
        .rs_data (rs_rf),
        .rt_data (rt_rf),
        .wr_en   (wb_en),
        .wr_addr (wb_addr),
        .wr_data (wb_data)
    );

    always_comb begin
        ctrl    = '0;
        dest    = rt;
        imm_ext = {{16{if_id.instr[15]}}, if_id.instr[15:0]};
        uses_rs = 1'b1;
        uses_rt = 1'b0;
        is_beq  = 1'b0;
        is_bne  = 1'b0;
        is_jump = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                ctrl.reg_write = 1'b1;
                dest           = rd;
                uses_rt        = 1'b1;
                case (funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_XOR:  ctrl.alu_op = ALU_XOR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    FN_SLL, FN_SRL: begin
                        ctrl.alu_op         = (funct == FN_SLL) ? ALU_SLL : ALU_SRL;
                        ctrl.shift_by_shamt = 1'b1;
                        uses_rs             = 1'b0;
                    end
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_ANDI, OP_ORI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = (opcode == OP_ANDI) ? ALU_AND : ALU_OR;
                imm_ext          = {16'h0, if_id.instr[15:0]};
            end
            OP_LUI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = ALU_LUI;
                imm_ext          = {16'h0, if_id.instr[15:0]};
                uses_rs          = 1'b0;
            end
            OP_LW: begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_SW: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                uses_rt          = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                is_beq  = (opcode == OP_BEQ);
                is_bne  = (opcode == OP_BNE);
                uses_rt = 1'b1;
            end
            OP_J: begin
                is_jump = 1'b1;
                uses_rs = 1'b0;
            end
            default: uses_rs = 1'b0;
        endcase
        // writes to r0 are dropped here so they never forward
        if (dest == '0) begin
            ctrl.reg_write = 1'b0;
        end
    end

    // execute first, then memory, else the register file
    function automatic word_t forward(reg_addr_t src, word_t rf_value);
        word_t value;
        value = rf_value;
        if (ex_fwd.ctrl.reg_write && !ex_fwd.ctrl.mem_to_reg && ex_fwd.dest == src) begin
            value = ex_result;
        end else if (mem_fwd.ctrl.reg_write && mem_fwd.dest == src) begin
            value = mem_fwd.ctrl.mem_to_reg ? mem_rdata : mem_fwd.alu_result;
        end
        return value;
    endfunction

    always_comb begin
        rs_val     = forward(rs, rs_rf);
        rt_val     = forward(rt, rt_rf);
        ex_is_load = ex_fwd.ctrl.reg_write && ex_fwd.ctrl.mem_to_reg;
        stall      = ex_is_load && ((uses_rs && ex_fwd.dest == rs) ||
                                    (uses_rt && ex_fwd.dest == rt));
        taken      = is_jump || (is_beq && rs_val == rt_val) || (is_bne && rs_val != rt_val);
        redirect   = taken && !stall;
        if (is_jump) begin
            redirect_pc = {if_id.pc_plus4[31:28], if_id.instr[25:0], 2'b00};
        end else begin
            redirect_pc = if_id.pc_plus4 + {imm_ext[29:0], 2'b00};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex.ctrl <= '0;
        end else if (en) begin
            // bubble on a load-use hazard
            id_ex.ctrl <= stall ? ctrl_t'('0) : ctrl;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            id_ex.op_a  <= rs_val;
            id_ex.op_b  <= rt_val;
            id_ex.imm   <= imm_ext;
            id_ex.shamt <= shamt;
            id_ex.dest  <= dest;
        end
    end

endmodule

`default_nettype wire

// File: source/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        en,
    input  wire cpu_pipe_pkg::id_ex_t  id_ex,
    output cpu_isa_pkg::word_t         result,
    output cpu_pipe_pkg::ex_mem_t      ex_mem
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    word_t alu_a;
    word_t alu_b;

    always_comb begin
        // shifts take rt as the value and shamt as the distance
        alu_a = id_ex.ctrl.shift_by_shamt ? {27'b0, id_ex.shamt} : id_ex.op_a;
        alu_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : id_ex.op_b;
        case (id_ex.ctrl.alu_op)
            ALU_ADD: result = alu_a + alu_b;
            ALU_SUB: result = alu_a - alu_b;
            ALU_AND: result = alu_a & alu_b;
            ALU_OR:  result = alu_a | alu_b;
            ALU_XOR: result = alu_a ^ alu_b;
            ALU_SLT: result = {31'b0, $signed(alu_a) < $signed(alu_b)};
            ALU_SLL: result = alu_b << alu_a[4:0];
            ALU_SRL: result = alu_b >> alu_a[4:0];
            ALU_LUI: result = {alu_b[15:0], 16'h0};
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem.ctrl <= '0;
        end else if (en) begin
            ex_mem.ctrl <= id_ex.ctrl;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            ex_mem.alu_result <= result;
            ex_mem.store_data <= id_ex.op_b;
            ex_mem.dest       <= id_ex.dest;
        end
    end

endmodule

`default_nettype wire

// File: source/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter cpu_isa_pkg::word_t RESET_PC = '0
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        en,
    input  wire                        stall,
    input  wire                        redirect,
    input  wire cpu_isa_pkg::word_t    redirect_pc,
    input  wire cpu_isa_pkg::word_t    instr,
    output cpu_isa_pkg::word_t         pc,
    output cpu_pipe_pkg::if_id_t       if_id
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    word_t pc_plus4;

    assign pc_plus4 = pc + 32'd4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc    <= RESET_PC;
            if_id <= '0;
        end else if (en) begin
            // redirect takes priority over stall
            if (redirect) begin
                pc    <= redirect_pc;
                if_id <= '0;
            end else if (!stall) begin
                pc             <= pc_plus4;
                if_id.pc_plus4 <= pc_plus4;
                if_id.instr    <= instr;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/pipeline_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_cpu #(
    parameter cpu_isa_pkg::word_t RESET_PC = '0
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     cpu_en,
    input  wire cpu_isa_pkg::word_t instr,
    output cpu_isa_pkg::word_t      pc_out,
    output cpu_isa_pkg::word_t      mem_addr,
    output cpu_isa_pkg::word_t      mem_wdata,
    output logic                    mem_write,
    input  wire cpu_isa_pkg::word_t mem_rdata
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;
    word_t   ex_result;
    word_t   redirect_pc;
    word_t   wb_data;
    logic    stall;
    logic    redirect;
    logic    wb_en;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (cpu_en),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .instr       (instr),
        .pc          (pc_out),
        .if_id       (if_id)
    );

    decode_stage u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (cpu_en),
        .if_id       (if_id),
        .ex_fwd      (id_ex),
        .ex_result   (ex_result),
        .mem_fwd     (ex_mem),
        .mem_rdata   (mem_rdata),
        .wb_en       (wb_en),
        .wb_addr     (mem_wb.dest),
        .wb_data     (wb_data),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .id_ex       (id_ex)
    );

    execute_stage u_execute (
        .clk    (clk),
        .rst_n  (rst_n),
        .en     (cpu_en),
        .id_ex  (id_ex),
        .result (ex_result),
        .ex_mem (ex_mem)
    );

    // data memory sits outside and answers in the same cycle
    assign mem_addr  = ex_mem.alu_result;
    assign mem_wdata = ex_mem.store_data;
    assign mem_write = ex_mem.ctrl.mem_write;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_wb.reg_write  <= 1'b0;
            mem_wb.mem_to_reg <= 1'b0;
        end else if (cpu_en) begin
            mem_wb.reg_write  <= ex_mem.ctrl.reg_write;
            mem_wb.mem_to_reg <= ex_mem.ctrl.mem_to_reg;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_en) begin
            mem_wb.alu_result <= ex_mem.alu_result;
            mem_wb.mem_data   <= mem_rdata;
            mem_wb.dest       <= ex_mem.dest;
        end
    end

    // no register write while frozen
    assign wb_en   = mem_wb.reg_write && cpu_en;
    assign wb_data = mem_wb.mem_to_reg ? mem_wb.mem_data : mem_wb.alu_result;

endmodule

`default_nettype wire

// File: source/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire                         clk,
    input  wire cpu_isa_pkg::reg_addr_t rs_addr,
    input  wire cpu_isa_pkg::reg_addr_t rt_addr,
    output cpu_isa_pkg::word_t          rs_data,
    output cpu_isa_pkg::word_t          rt_data,
    input  wire                         wr_en,
    input  wire cpu_isa_pkg::reg_addr_t wr_addr,
    input  wire cpu_isa_pkg::word_t     wr_data
);
    import cpu_isa_pkg::*;

    word_t regs [32];

    // r0 reads zero and a same-cycle write passes straight through
    function automatic word_t read_port(reg_addr_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (wr_en && wr_addr == addr) begin
            value = wr_data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    always_comb begin
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

endmodule

`default_nettype wire

// File: verification/pipeline_cpu_sva.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_cpu_sva #(
    parameter cpu_isa_pkg::word_t RESET_PC = '0
) (
    input wire                     clk,
    input wire                     rst_n,
    input wire                     cpu_en,
    input wire                     stall,
    input wire                     mem_write,
    input wire cpu_isa_pkg::word_t pc_out,
    input wire cpu_isa_pkg::word_t mem_addr,
    input wire cpu_isa_pkg::word_t mem_wdata
);
    int unsigned fail_count = 0;

    // fetch restarts at the reset address with no store pending
    reset_state: assert property (@(posedge clk)
        !rst_n |=> (pc_out == RESET_PC && !mem_write))
    else begin
        fail_count++;
        $error("pc_out or mem_write wrong after reset");
    end

    // frozen pipeline keeps fetch and data address
    freeze_hold: assert property (@(posedge clk)
        (rst_n && !cpu_en) |=> ($stable(pc_out) && $stable(mem_addr)))
    else begin
        fail_count++;
        $error("pc_out or mem_addr moved while cpu_en was low");
    end

    strobe_sane: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(mem_write) &&
        (!mem_write || (!$isunknown({mem_addr, mem_wdata}) && mem_addr[1:0] == 2'b00)))
    else begin
        fail_count++;
        $error("store strobe unknown or store address misaligned");
    end

    // load-use bubble holds pc once and clears by the next enabled cycle
    stall_one: assert property (@(posedge clk) disable iff (!rst_n)
        (cpu_en && stall) |=> ($stable(pc_out) ##0 cpu_en[->1] ##0 !stall))
    else begin
        fail_count++;
        $error("load-use stall did not last exactly one enabled cycle");
    end

endmodule

bind pipeline_cpu pipeline_cpu_sva #(
    .RESET_PC (RESET_PC)
) u_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .cpu_en    (cpu_en),
    .stall     (stall),
    .mem_write (mem_write),
    .pc_out    (pc_out),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata)
);

`default_nettype wire

// File: verification/pipeline_cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_cpu_tb;
    import cpu_isa_pkg::*;

    localparam int    CLK_PERIOD  = 8;
    localparam int    PROG_LEN    = 37;
    localparam int    NUM_FREEZES = 6;
    localparam word_t START_PC    = 32'h0000_0000;

    logic   clk;
    logic   rst_n;
    logic   cpu_en;
    word_t  instr;
    word_t  pc_out;
    word_t  mem_addr;
    word_t  mem_wdata;
    logic   mem_write;
    word_t  mem_rdata;

    word_t  imem [256];
    word_t  dmem [256];
    word_t  gold_regs [32];
    logic   gold_written [32];
    word_t  exp_addr [$];
    word_t  exp_data [$];
    int     run_len [NUM_FREEZES];
    int     freeze_len [NUM_FREEZES];
    int     freeze_total;
    int     exp_count;
    int     store_count;
    int     errors;
    integer seed;
    logic   limit_ready = 1'b0;

    pipeline_cpu #(
        .RESET_PC (START_PC)
    ) dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_en    (cpu_en),
        .instr     (instr),
        .pc_out    (pc_out),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_write (mem_write),
        .mem_rdata (mem_rdata)
    );

    // both memories answer in the same cycle
    assign instr     = imem[pc_out[9:2]];
    assign mem_rdata = dmem[mem_addr[9:2]];

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic word_t rtype_word(funct_e fn, int rd, int rs, int rt, int sh);
        return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
    endfunction

    // argument order is rt, then rs (base for lw and sw)
    function automatic word_t itype_word(opcode_e op, int rt, int rs, int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic word_t jump_word(int target_index);
        return {OP_J, target_index[25:0]};
    endfunction

    task automatic load_program();
        foreach (imem[i]) imem[i] = '0;
        foreach (dmem[i]) dmem[i] = 32'h3c00_0000 + i * 32'h0004_0101;
        imem[0]  = itype_word(OP_ADDIU, 10, 0, 16'h0100);
        imem[1]  = itype_word(OP_ADDIU, 1, 0, 16'h1234);
        imem[2]  = rtype_word(FN_ADDU, 2, 1, 1, 0);
        imem[3]  = rtype_word(FN_SUBU, 3, 2, 1, 0);
        imem[4]  = itype_word(OP_SW, 3, 10, 0);
        imem[5]  = itype_word(OP_LUI, 4, 0, 16'h8765);
        imem[6]  = itype_word(OP_ORI, 4, 4, 16'h4321);
        imem[7]  = itype_word(OP_SW, 4, 10, 4);
        imem[8]  = rtype_word(FN_XOR, 5, 4, 2, 0);
        imem[9]  = itype_word(OP_SW, 5, 10, 8);
        imem[10] = rtype_word(FN_AND, 6, 5, 4, 0);
        imem[11] = rtype_word(FN_OR, 7, 6, 3, 0);
        imem[12] = itype_word(OP_SW, 7, 10, 12);
        imem[13] = rtype_word(FN_SLT, 8, 4, 1, 0);
        imem[14] = rtype_word(FN_SLL, 9, 0, 7, 4);
        imem[15] = rtype_word(FN_SRL, 11, 0, 4, 8);
        imem[16] = itype_word(OP_SW, 8, 10, 16);
        imem[17] = itype_word(OP_SW, 9, 10, 20);
        imem[18] = itype_word(OP_SW, 11, 10, 24);
        // load then immediate use
        imem[19] = itype_word(OP_LW, 13, 10, 4);
        imem[20] = itype_word(OP_ADDIU, 14, 13, 1);
        imem[21] = itype_word(OP_SW, 14, 10, 28);
        // load data forwarded from the memory stage
        imem[22] = itype_word(OP_LW, 15, 10, 0);
        imem[23] = itype_word(OP_ANDI, 16, 4, 16'hff00);
        imem[24] = rtype_word(FN_SUBU, 17, 15, 16, 0);
        imem[25] = itype_word(OP_SW, 17, 10, 32);
        imem[26] = rtype_word(FN_ADDU, 18, 1, 0, 0);
        imem[27] = itype_word(OP_BEQ, 3, 18, 1);
        imem[28] = itype_word(OP_SW, 1, 10, 36);
        imem[29] = itype_word(OP_BEQ, 2, 1, 1);
        imem[30] = itype_word(OP_SW, 2, 10, 40);
        imem[31] = itype_word(OP_BNE, 2, 1, 1);
        imem[32] = itype_word(OP_SW, 1, 10, 44);
        imem[33] = jump_word(35);
        imem[34] = itype_word(OP_SW, 1, 10, 48);
        imem[35] = itype_word(OP_SW, 6, 10, 52);
        imem[36] = jump_word(36);
    endtask

    task automatic write_gold_reg(logic [4:0] r, word_t value);
        if (r != 5'd0) begin
            gold_regs[r]    = value;
            gold_written[r] = 1'b1;
        end
    endtask

    // plain ISA interpreter that stops at a jump to itself
    task automatic run_golden();
        word_t gmem [256];
        word_t pc;
        word_t ins;
        word_t rs_v;
        word_t rt_v;
        word_t simm;
        word_t zimm;
        word_t ea;
        word_t next_pc;
        int    steps;
        gmem  = dmem;
        pc    = START_PC;
        steps = 0;
        foreach (gold_regs[i]) begin
            gold_regs[i]    = '0;
            gold_written[i] = 1'b0;
        end
        while (steps < 1000) begin
            ins     = imem[pc[9:2]];
            rs_v    = gold_regs[ins[25:21]];
            rt_v    = gold_regs[ins[20:16]];
            simm    = {{16{ins[15]}}, ins[15:0]};
            zimm    = {16'h0, ins[15:0]};
            ea      = rs_v + simm;
            next_pc = pc + 32'd4;
            steps++;
            case (ins[31:26])
                OP_RTYPE: begin
                    case (ins[5:0])
                        FN_ADDU: write_gold_reg(ins[15:11], rs_v + rt_v);
                        FN_SUBU: write_gold_reg(ins[15:11], rs_v - rt_v);
                        FN_AND:  write_gold_reg(ins[15:11], rs_v & rt_v);
                        FN_OR:   write_gold_reg(ins[15:11], rs_v | rt_v);
                        FN_XOR:  write_gold_reg(ins[15:11], rs_v ^ rt_v);
                        FN_SLT:  write_gold_reg(ins[15:11],
                                     ($signed(rs_v) < $signed(rt_v)) ? 32'd1 : 32'd0);
                        FN_SLL:  write_gold_reg(ins[15:11], rt_v << ins[10:6]);
                        FN_SRL:  write_gold_reg(ins[15:11], rt_v >> ins[10:6]);
                        default: ;
                    endcase
                end
                OP_ADDIU: write_gold_reg(ins[20:16], rs_v + simm);
                OP_ANDI:  write_gold_reg(ins[20:16], rs_v & zimm);
                OP_ORI:   write_gold_reg(ins[20:16], rs_v | zimm);
                OP_LUI:   write_gold_reg(ins[20:16], {ins[15:0], 16'h0});
                OP_LW:    write_gold_reg(ins[20:16], gmem[ea[9:2]]);
                OP_SW: begin
                    gmem[ea[9:2]] = rt_v;
                    exp_addr.push_back(ea);
                    exp_data.push_back(rt_v);
                end
                OP_BEQ: if (rs_v == rt_v) next_pc = pc + 32'd4 + (simm << 2);
                OP_BNE: if (rs_v != rt_v) next_pc = pc + 32'd4 + (simm << 2);
                OP_J: begin
                    next_pc = {next_pc[31:28], ins[25:0], 2'b00};
                    if (next_pc == pc) break;
                end
                default: ;
            endcase
            pc = next_pc;
        end
        exp_count = exp_addr.size();
    endtask

    task automatic plan_freezes();
        freeze_total = 0;
        for (int k = 0; k < NUM_FREEZES; k++) begin
            run_len[k]    = 2 + ($unsigned($random(seed)) % 6);
            freeze_len[k] = 1 + ($unsigned($random(seed)) % 4);
            freeze_total += freeze_len[k];
        end
    endtask

    task automatic compare_registers();
        for (int r = 1; r < 32; r++) begin
            if (gold_written[r]) begin
                assert (dut0.u_decode.u_regs.regs[r] == gold_regs[r])
                else begin
                    errors++;
                    $display("** Error at %0t ns: r%0d holds %h, expected %h", $time, r,
                             dut0.u_decode.u_regs.regs[r], gold_regs[r]);
                end
            end
        end
    endtask

    // store monitor that also writes the data memory
    always @(posedge clk) begin
        if (rst_n && cpu_en && mem_write) begin
            if (store_count >= exp_count) begin
                errors++;
                $display("unexpected extra store of %h to %h at %0t ns", mem_wdata, mem_addr,
                         $time);
            end else begin
                assert (mem_addr == exp_addr[store_count] && mem_wdata == exp_data[store_count])
                else begin
                    errors++;
                    $display("** Error at %0t ns: store %0d wrote %h to %h, expected %h to %h",
                             $time, store_count, mem_wdata, mem_addr,
                             exp_data[store_count], exp_addr[store_count]);
                end
            end
            store_count++;
            dmem[mem_addr[9:2]] <= mem_wdata;
        end
    end

    initial begin
        int limit_cycles;
        wait (limit_ready);
        limit_cycles = 40 * PROG_LEN + freeze_total + 5;
        #(limit_cycles * CLK_PERIOD);
        $display("watchdog expired after %0d cycles with %0d of %0d stores seen",
                 limit_cycles, store_count, exp_count);
        $display("Test failed");
        $finish;
    end

    initial begin
        seed        = 32'h59dc_c12d;
        rst_n       = 1'b0;
        cpu_en      = 1'b1;
        store_count = 0;
        errors      = 0;
        exp_count   = 0;
        load_program();
        run_golden();
        plan_freezes();
        limit_ready = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // random freeze stretches while the program runs
        for (int k = 0; k < NUM_FREEZES; k++) begin
            repeat (run_len[k]) @(posedge clk);
            #1;
            cpu_en = 1'b0;
            repeat (freeze_len[k]) @(posedge clk);
            #1;
            cpu_en = 1'b1;
        end
        while (store_count < exp_count) @(posedge clk);
        // drain writeback and catch any late surplus store
        repeat (12) @(posedge clk);
        compare_registers();
        $display("stores %0d of %0d, errors %0d, assertion failures %0d",
                 store_count, exp_count, errors, dut0.u_sva.fail_count);
        if (errors == 0 && dut0.u_sva.fail_count == 0 && store_count == exp_count) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
